//--- design/pce_pad_consts.svh
`ifndef PCE_PAD_CONSTS_SVH
`define PCE_PAD_CONSTS_SVH

// ====================
// Controller port sizes
// ====================

// Multitap ports behind the console pad bus
`define PAD_PORTS 5

// Index width wide enough to run past the last port
`define PORT_IDX_W 3

// Host side joystick word
`define HOST_JOY_W 32

// Console side words
`define PAD_WORD_W 16
`define NIBBLE_W 4
`define DELTA_W 8

// Mouse idle timeout, saturates after 32767 cycles
`define MOUSE_TO_W 15

// Only this port can carry the mouse
`define MOUSE_PORT 0

`endif

//--- design/pce_pad_pkg.sv
`include "pce_pad_consts.svh"

package pce_pad_pkg;

	// Host joystick, bits 3:0 directions, 7:4 I/II/Select/Run, 11:8 III..VI
	typedef logic [`HOST_JOY_W-1:0] host_joy_t;

	// Active-low console pad word, four nibbles
	typedef logic [`PAD_WORD_W-1:0] pad_word_t;

	typedef logic [`NIBBLE_W-1:0] nibble_t;
	typedef logic [`DELTA_W-1:0] mouse_delta_t;
	typedef logic [`PORT_IDX_W-1:0] port_idx_t;
	typedef logic [`MOUSE_TO_W-1:0] mouse_to_t;

	// Mouse nibble sequence, one step per clr rising edge
	typedef enum logic [1:0] {
		MS_X_HI,
		MS_X_LO,
		MS_Y_HI,
		MS_Y_LO
	} mouse_nib_e;

	// Pad bus from the console, clr sits in the high bit
	typedef struct packed {
		logic clr;
		logic sel;
	} pad_bus_t;

	typedef struct packed {
		pad_word_t [`PAD_PORTS-1:0] word;
	} pad_set_t;

	// Option levels, no handshake
	typedef struct packed {
		logic joy_swap;
		logic turbotap;
		logic buttons6;
		logic mouse_en;
	} pad_opts_t;

endpackage

//--- design/pad_map.sv
`timescale 1ns/1ps
`include "pce_pad_consts.svh"

module pad_map (
	input  pce_pad_pkg::host_joy_t joy_a,
	input  pce_pad_pkg::host_joy_t joy_b,
	input  pce_pad_pkg::host_joy_t joy_2,
	input  pce_pad_pkg::host_joy_t joy_3,
	input  pce_pad_pkg::host_joy_t joy_4,
	input  logic                   joy_swap,
	output pce_pad_pkg::pad_set_t  pads,
	output logic [1:0]             pad_buttons
);
	import pce_pad_pkg::*;

	host_joy_t joy_port [`PAD_PORTS];

	// ====================
	// Host to console layout
	// ====================

	// Nibble 0 buttons I, II, Select, Run
	// Nibble 1 up, right, down, left
	// Nibble 2 buttons III to VI, nibble 3 stays zero
	function automatic pad_word_t map_joy(input host_joy_t j);
		map_joy = ~{4'hF, j[11:8], j[1], j[2], j[0], j[3], j[7:4]};
	endfunction

	// Swap only touches the first two ports
	assign joy_port[0] = joy_swap ? joy_b : joy_a;
	assign joy_port[1] = joy_swap ? joy_a : joy_b;
	assign joy_port[2] = joy_2;
	assign joy_port[3] = joy_3;
	assign joy_port[4] = joy_4;

	always_comb begin
		for (int i = 0; i < `PAD_PORTS; i++) begin
			pads.word[i] = map_joy(joy_port[i]);
		end
	end

	// Buttons II and I of the port carrying the mouse, active high here
	assign pad_buttons = joy_port[`MOUSE_PORT][5:4];

endmodule

//--- design/mouse_tracker.sv
`timescale 1ns/1ps
`include "pce_pad_consts.svh"

module mouse_tracker (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [8:0]             mouse_x,
	input  logic [8:0]             mouse_y,
	input  logic [7:0]             mouse_flags,
	input  logic                   mouse_strobe,
	input  logic                   clr,
	input  logic                   clr_rise,
	input  logic [1:0]             pad_buttons,
	output pce_pad_pkg::pad_word_t mouse_word
);
	import pce_pad_pkg::*;

	// Deltas gathered since the last readout
	mouse_delta_t acc_x;
	mouse_delta_t acc_y;

	// Deltas being read out by the console
	mouse_delta_t lat_x;
	mouse_delta_t lat_y;

	mouse_nib_e nib;
	mouse_to_t  to_cnt;
	logic       to_sat;

	nibble_t btn_n;
	nibble_t cur_nib;

	// ====================
	// Idle timeout
	// ====================

	assign to_sat = &to_cnt;

	// Counts only while clr is low, holds at the top
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			to_cnt <= '0;
		end else if (clr) begin
			to_cnt <= '0;
		end else if (!to_sat) begin
			to_cnt <= to_cnt + 1'b1;
		end
	end

	// ====================
	// Nibble sequence
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nib   <= MS_Y_LO;
			acc_x <= '0;
			acc_y <= '0;
			lat_x <= '0;
			lat_y <= '0;
		end else begin
			// Stale readout restarts at x high
			if (to_sat) begin
				nib <= MS_Y_LO;
			end

			if (clr_rise) begin
				nib <= mouse_nib_e'(nib + 2'd1);
				// Wrap from y low hands the gathered deltas over
				if (nib == MS_Y_LO) begin
					lat_x <= acc_x;
					lat_y <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end

			// A strobe beats the clear above
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x[7:0];
				acc_y <= mouse_y[7:0];
			end
		end
	end

	// ====================
	// Mouse word
	// ====================

	// Buttons II and I, then left and right, all active low
	assign btn_n = ~{pad_buttons, mouse_flags[0], mouse_flags[1]};

	always_comb begin
		case (nib)
			MS_X_HI: cur_nib = lat_x[7:4];
			MS_X_LO: cur_nib = lat_x[3:0];
			MS_Y_HI: cur_nib = lat_y[7:4];
			default: cur_nib = lat_y[3:0];
		endcase
	end

	// Same pair in both banks
	assign mouse_word = {cur_nib, btn_n, cur_nib, btn_n};

endmodule

//--- design/tap_scanner.sv
`timescale 1ns/1ps
`include "pce_pad_consts.svh"

module tap_scanner (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  pce_pad_pkg::pad_bus_t  pad_bus,
	input  pce_pad_pkg::pad_opts_t opts,
	input  pce_pad_pkg::pad_set_t  pads,
	input  pce_pad_pkg::pad_word_t mouse_word,
	output logic                   clr_rise,
	output pce_pad_pkg::nibble_t   joy_in
);
	import pce_pad_pkg::*;

	pad_bus_t  bus_q;
	port_idx_t port;
	logic      bank;
	logic      sel_rise;

	pad_word_t  cur_word;
	logic [1:0] nib_idx;
	nibble_t    cur_nib;

	// ====================
	// Pad bus edges
	// ====================

	// Compared against last cycle's bus
	assign clr_rise = pad_bus.clr & ~bus_q.clr;
	assign sel_rise = pad_bus.sel & ~bus_q.sel;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus_q <= '0;
		end else begin
			bus_q <= pad_bus;
		end
	end

	// ====================
	// Port and bank
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			port <= '0;
			bank <= 1'b0;
		end else if (pad_bus.clr) begin
			port <= '0;
			// Six-button pads flip bank on each clr rise
			if (clr_rise) begin
				bank <= ~bank & opts.buttons6;
			end
		end else if (sel_rise && opts.turbotap) begin
			port <= port + 1'b1;
		end
	end

	// ====================
	// Nibble select
	// ====================

	always_comb begin
		if (port == `MOUSE_PORT && opts.mouse_en) begin
			cur_word = mouse_word;
		end else if (port < `PAD_PORTS) begin
			cur_word = pads.word[port];
		end else begin
			// Nothing plugged past the last port
			cur_word = 16'h0FFF;
		end
	end

	// Bank picks the upper half of the word
	assign nib_idx = {bank, pad_bus.sel};
	assign cur_nib = cur_word[{nib_idx, 2'b00} +: 4];

	// Output nibble, zero while clr is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			joy_in <= '0;
		end else if (pad_bus.clr) begin
			joy_in <= '0;
		end else begin
			joy_in <= cur_nib;
		end
	end

endmodule

//--- design/pce_pad_top.sv
`timescale 1ns/1ps

module pce_pad_top (
	input  logic                   clk_sys,
	input  logic                   reset,

	// Host joysticks
	input  pce_pad_pkg::host_joy_t joy_a,
	input  pce_pad_pkg::host_joy_t joy_b,
	input  pce_pad_pkg::host_joy_t joy_2,
	input  pce_pad_pkg::host_joy_t joy_3,
	input  pce_pad_pkg::host_joy_t joy_4,

	// Host mouse
	input  logic [8:0]             mouse_x,
	input  logic [8:0]             mouse_y,
	input  logic [7:0]             mouse_flags,
	input  logic                   mouse_strobe,

	input  pce_pad_pkg::pad_opts_t opts,

	// Console side
	input  pce_pad_pkg::pad_bus_t  pad_bus,
	output pce_pad_pkg::nibble_t   joy_in
);
	import pce_pad_pkg::*;

	pad_set_t   pads;
	pad_word_t  mouse_word;
	logic [1:0] pad_buttons;
	logic       clr_rise;

	// ====================
	// Input side
	// ====================

	pad_map u_pad_map (
		.joy_a       (joy_a),
		.joy_b       (joy_b),
		.joy_2       (joy_2),
		.joy_3       (joy_3),
		.joy_4       (joy_4),
		.joy_swap    (opts.joy_swap),
		.pads        (pads),
		.pad_buttons (pad_buttons)
	);

	mouse_tracker u_mouse_tracker (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mouse_x      (mouse_x),
		.mouse_y      (mouse_y),
		.mouse_flags  (mouse_flags),
		.mouse_strobe (mouse_strobe),
		.clr          (pad_bus.clr),
		.clr_rise     (clr_rise),
		.pad_buttons  (pad_buttons),
		.mouse_word   (mouse_word)
	);

	// ====================
	// Scanner and output
	// ====================

	tap_scanner u_tap_scanner (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pad_bus    (pad_bus),
		.opts       (opts),
		.pads       (pads),
		.mouse_word (mouse_word),
		.clr_rise   (clr_rise),
		.joy_in     (joy_in)
	);

endmodule

//--- verification/pce_pad_chk.sv
`timescale 1ns/1ps
`include "pce_pad_consts.svh"

module pce_pad_chk (
	input logic                   clk_sys,
	input logic                   reset,
	input pce_pad_pkg::host_joy_t joy_a, joy_b, joy_2, joy_3, joy_4,
	input logic [8:0]             mouse_x, mouse_y,
	input logic [7:0]             mouse_flags,
	input logic                   mouse_strobe,
	input pce_pad_pkg::pad_opts_t opts,
	input pce_pad_pkg::pad_bus_t  pad_bus,
	input pce_pad_pkg::nibble_t   joy_in
);
	import pce_pad_pkg::*;

	int unsigned fail_cnt = 0;

	// Shadow state
	pad_bus_t               bus_prev;
	logic [`PORT_IDX_W-1:0] port_s;
	logic                   bank_s;
	logic [1:0]             step_s;
	logic [`MOUSE_TO_W-1:0] idle_s;
	mouse_delta_t           acc_x, acc_y, lat_x, lat_y;
	nibble_t                exp_joy;

	logic      clr_up, sel_up, wrap;
	host_joy_t first, second;
	nibble_t   m_nib, m_btn, nib_s;
	pad_word_t word_s;

	// Console word, active low, directions as up/right/down/left from bit 0
	function automatic pad_word_t console_word(input host_joy_t j);
		logic up, right, down, left;
		right = j[0];
		left  = j[1];
		down  = j[2];
		up    = j[3];
		return ~{4'hF, j[11:8], left, down, right, up, j[7:4]};
	endfunction

	assign clr_up = pad_bus.clr && !bus_prev.clr;
	assign sel_up = pad_bus.sel && !bus_prev.sel;
	assign wrap   = clr_up && step_s == 2'd3;

	// ====================
	// Expected nibble
	// ====================

	always_comb begin
		first  = opts.joy_swap ? joy_b : joy_a;
		second = opts.joy_swap ? joy_a : joy_b;
		m_btn  = ~{first[5], first[4], mouse_flags[0], mouse_flags[1]};
		case (step_s)
			2'd0: m_nib = lat_x[7:4];
			2'd1: m_nib = lat_x[3:0];
			2'd2: m_nib = lat_y[7:4];
			default: m_nib = lat_y[3:0];
		endcase
		case (port_s)
			3'd0: word_s = opts.mouse_en ? {m_nib, m_btn, m_nib, m_btn} : console_word(first);
			3'd1: word_s = console_word(second);
			3'd2: word_s = console_word(joy_2);
			3'd3: word_s = console_word(joy_3);
			3'd4: word_s = console_word(joy_4);
			default: word_s = {4'h0, 4'hF, 4'hF, 4'hF};
		endcase
		nib_s = word_s[4 * {bank_s, pad_bus.sel} +: 4];
	end

	// ====================
	// Shadow registers
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus_prev <= '0;
			port_s   <= '0;
			bank_s   <= 1'b0;
			step_s   <= 2'd3;
			idle_s   <= '0;
			acc_x    <= '0;
			acc_y    <= '0;
			lat_x    <= '0;
			lat_y    <= '0;
			exp_joy  <= '0;
		end else begin
			bus_prev <= pad_bus;
			if (pad_bus.clr) begin
				port_s <= '0;
			end else if (sel_up && opts.turbotap) begin
				port_s <= port_s + 1'b1;
			end
			if (clr_up) begin
				bank_s <= !bank_s && opts.buttons6;
			end
			idle_s <= pad_bus.clr ? '0 : (idle_s == '1 ? idle_s : idle_s + 1'b1);
			// A clr edge beats the idle restart
			if (clr_up) begin
				step_s <= step_s + 2'd1;
			end else if (idle_s == '1) begin
				step_s <= 2'd3;
			end
			if (wrap) begin
				lat_x <= acc_x;
				lat_y <= acc_y;
			end
			if (mouse_strobe) begin
				acc_x <= 8'd0 - mouse_x[7:0];
				acc_y <= mouse_y[7:0];
			end else if (wrap) begin
				acc_x <= '0;
				acc_y <= '0;
			end
			exp_joy <= pad_bus.clr ? '0 : nib_s;
		end
	end

	// ====================
	// Assertions
	// ====================

	a_reset_zero: assert property (@(posedge clk_sys) $fell(reset) |-> joy_in == '0)
		else begin
			fail_cnt++;
			$error("** Error joy_in after reset: expected 0, got %h", $sampled(joy_in));
		end

	a_clr_zero: assert property (@(posedge clk_sys) disable iff (reset)
		pad_bus.clr |=> joy_in == '0)
		else begin
			fail_cnt++;
			$error("** Error joy_in after clr: expected 0, got %h", $sampled(joy_in));
		end

	a_joy_in: assert property (@(posedge clk_sys) disable iff (reset) joy_in == exp_joy)
		else begin
			fail_cnt++;
			$error("** Error joy_in: expected %h, got %h", $sampled(exp_joy), $sampled(joy_in));
		end

endmodule

bind pce_pad_top pce_pad_chk chk (.*);

//--- verification/pce_pad_tb.sv
`timescale 1ns/1ps

module pce_pad_tb;
	import pce_pad_pkg::*;

	logic       clk_sys = 1'b0;
	logic       reset;
	host_joy_t  joy_a, joy_b, joy_2, joy_3, joy_4;
	logic [8:0] mouse_x, mouse_y;
	logic [7:0] mouse_flags;
	logic       mouse_strobe;
	pad_opts_t  opts;
	pad_bus_t   pad_bus;
	nibble_t    joy_in;

	logic [31:0] rnd = 32'h152d;
	int unsigned tb_errors = 0;

	pce_pad_top dut (.*);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Upper LCG bits land in the low joystick bits
	function automatic host_joy_t joy_from(input logic [31:0] s);
		return {s[15:0], s[31:16]};
	endfunction

	task automatic load_joys();
		rnd   = lcg_next(rnd);
		joy_a = joy_from(rnd);
		rnd   = lcg_next(rnd);
		joy_b = joy_from(rnd);
		rnd   = lcg_next(rnd);
		joy_2 = joy_from(rnd);
		rnd   = lcg_next(rnd);
		joy_3 = joy_from(rnd);
		rnd   = lcg_next(rnd);
		joy_4 = joy_from(rnd);
	endtask

	task automatic cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic end_run();
		int unsigned chk_errors;
		chk_errors = dut.chk.fail_cnt;
		$display("Errors: %0d assertion, %0d testbench", chk_errors, tb_errors);
		if (chk_errors == 0 && tb_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	// ====================
	// Pad bus sequences
	// ====================

	task automatic drive_bus(input logic clr, input logic sel, input int hold);
		@(negedge clk_sys);
		pad_bus.clr = clr;
		pad_bus.sel = sel;
		cycles(hold - 1);
	endtask

	// Raise clr until the output reads zero, then drop it
	task automatic clear_pulse();
		int waited;
		waited = 0;
		drive_bus(1'b1, pad_bus.sel, 1);
		@(negedge clk_sys);
		while (joy_in != '0 && waited < 8) begin
			@(negedge clk_sys);
			waited++;
		end
		if (joy_in == '0) begin
			drive_bus(1'b0, pad_bus.sel, 2);
		end else begin
			$display("Timeout: joy_in did not clear while clr was high");
			tb_errors++;
			end_run();
		end
	endtask

	task automatic scan_sel(input int steps);
		for (int i = 0; i < steps; i++) begin
			drive_bus(1'b0, 1'b0, 2);
			drive_bus(1'b0, 1'b1, 2);
		end
	endtask

	task automatic strobe_mouse(input logic with_clr);
		@(negedge clk_sys);
		rnd          = lcg_next(rnd);
		mouse_x      = rnd[24:16];
		mouse_y      = rnd[8:0];
		mouse_flags  = rnd[31:24];
		mouse_strobe = 1'b1;
		pad_bus.clr  = with_clr;
		@(negedge clk_sys);
		mouse_strobe = 1'b0;
		pad_bus.clr  = 1'b0;
		cycles(1);
	endtask

	initial begin
		reset        = 1'b1;
		joy_a        = '0;
		joy_b        = '0;
		joy_2        = '0;
		joy_3        = '0;
		joy_4        = '0;
		mouse_x      = '0;
		mouse_y      = '0;
		mouse_flags  = '0;
		mouse_strobe = 1'b0;
		opts         = '0;
		pad_bus      = '0;
		cycles(16);
		reset = 1'b0;

		// Single port, plain then swapped
		for (int pass = 0; pass < 2; pass++) begin
			opts          = '0;
			opts.joy_swap = pass[0];
			load_joys();
			clear_pulse();
			scan_sel(3);
		end

		// Multitap walk past the last port, both banks
		for (int pass = 0; pass < 2; pass++) begin
			opts          = '0;
			opts.turbotap = 1'b1;
			opts.buttons6 = pass[0];
			load_joys();
			clear_pulse();
			scan_sel(9);
			clear_pulse();
			scan_sel(9);
		end

		// Six-button bank toggle, then held at 0
		for (int pass = 0; pass < 6; pass++) begin
			opts          = '0;
			opts.buttons6 = (pass < 3);
			load_joys();
			clear_pulse();
			scan_sel(1);
		end

		// Mouse on port 0
		opts          = '0;
		opts.mouse_en = 1'b1;
		// Move the nibble counter off y low before idling
		clear_pulse();
		strobe_mouse(1'b0);
		cycles(33000);
		for (int i = 0; i < 4; i++) begin
			clear_pulse();
			scan_sel(1);
		end
		// Strobe lands on the wrapping clr edge
		strobe_mouse(1'b1);
		for (int i = 0; i < 5; i++) begin
			clear_pulse();
			scan_sel(1);
		end

		end_run();
	end

endmodule

//--- files.f
+incdir+design
design/pce_pad_pkg.sv
design/pad_map.sv
design/mouse_tracker.sv
design/tap_scanner.sv
design/pce_pad_top.sv
verification/pce_pad_chk.sv
verification/pce_pad_tb.sv
